// ==== design/armCtrlPkg.sv ====
package armCtrlPkg;

  localparam int condW     = 4;
  localparam int flagW     = 4; // N Z C V
  localparam int aluCtrlW  = 4;
  localparam int multCtrlW = 3;

  // Instruction class in bits 27:26
  localparam logic [1:0] opDp     = 2'b00;
  localparam logic [1:0] opMem    = 2'b01;
  localparam logic [1:0] opBranch = 2'b10;

  localparam logic [aluCtrlW-1:0] aluAdd = 4'b0100; // Address and branch target math
  localparam logic [3:0]          pcReg  = 4'd15;

  localparam logic [condW-1:0] condEq = 4'b0000;
  localparam logic [condW-1:0] condNe = 4'b0001;
  localparam logic [condW-1:0] condCs = 4'b0010;
  localparam logic [condW-1:0] condCc = 4'b0011;
  localparam logic [condW-1:0] condMi = 4'b0100;
  localparam logic [condW-1:0] condPl = 4'b0101;
  localparam logic [condW-1:0] condVs = 4'b0110;
  localparam logic [condW-1:0] condVc = 4'b0111;
  localparam logic [condW-1:0] condHi = 4'b1000;
  localparam logic [condW-1:0] condLs = 4'b1001;
  localparam logic [condW-1:0] condGe = 4'b1010;
  localparam logic [condW-1:0] condLt = 4'b1011;
  localparam logic [condW-1:0] condGt = 4'b1100;
  localparam logic [condW-1:0] condLe = 4'b1101;
  localparam logic [condW-1:0] condAl = 4'b1110;

  typedef struct packed {
    logic [condW-1:0]    cond;
    logic [1:0]          op;
    logic                i;       // Immediate operand
    logic [aluCtrlW-1:0] cmd;
    logic                s;       // Set flags
    logic [3:0]          rn;
    logic [3:0]          rd;
    logic [11:0]         operand;
  } dpInstrT;

  typedef struct packed {
    logic [condW-1:0] cond;
    logic [1:0]       op;
    logic [5:0]       flags;      // I P U B W L, L in bit 0
    logic [3:0]       rn;
    logic [3:0]       rd;
    logic [11:0]      offset;
  } memInstrT;

  typedef struct packed {
    logic [condW-1:0] cond;
    logic [1:0]       op;
    logic [1:0]       funct;
    logic [23:0]      offset;     // Word offset from PC+8
  } brInstrT;

  typedef union packed {
    dpInstrT  dp;
    memInstrT mem;
    brInstrT  br;
  } armInstrT;

endpackage

// ==== design/decodeIf.sv ====
`timescale 1ns/10ps

interface decodeIf;
  import armCtrlPkg::*;

  logic                 aluSrc;
  logic [aluCtrlW-1:0]  aluControl;
  logic [multCtrlW-1:0] multControl;
  logic [1:0]           flagWrite;   // NZ, CV
  logic                 branch;
  logic                 memWrite;
  logic                 regWrite;
  logic                 memtoReg;
  logic                 pcSrc;
  logic [condW-1:0]     cond;

  modport dec (output aluSrc, aluControl, multControl, flagWrite, branch,
               memWrite, regWrite, memtoReg, pcSrc, cond);
  modport ctrl (input aluSrc, aluControl, multControl, flagWrite, branch,
                memWrite, regWrite, memtoReg, pcSrc, cond);

endinterface

// ==== design/hazardIf.sv ====
`timescale 1ns/10ps

interface hazardIf;

  // From controller
  logic regWriteM;
  logic memtoRegE;
  logic pcWrPendingF;
  logic branchTakenE;
  logic pcSrcW;

  // From hazard unit
  logic flushE;
  logic stallBack;   // Freezes E, M and W

  modport ctrl (output regWriteM, memtoRegE, pcWrPendingF, branchTakenE, pcSrcW,
                input  flushE, stallBack);
  modport haz (input  regWriteM, memtoRegE, pcWrPendingF, branchTakenE, pcSrcW,
               output flushE, stallBack);

endinterface

// ==== design/instrDecoder.sv ====
`timescale 1ns/10ps

module instrDecoder (
  input  armCtrlPkg::armInstrT instr,
  output logic [1:0]           regSrc,
  output logic [1:0]           immSrc,
  decodeIf.dec                 dec
);
  import armCtrlPkg::*;

  logic [9:0] controls;
  logic       aluSrc, memtoReg, regWrite, memWrite, branch;
  logic       aluOp;   // Data processing, ALU control comes from cmd
  logic       isMult;

  // Register form with 1001 in bits 7:4
  assign isMult = (instr.dp.op == opDp) && !instr.dp.i &&
                  (instr.dp.operand[7:4] == 4'b1001);

  // regSrc immSrc aluSrc memtoReg regWrite memWrite branch aluOp
  always_comb begin
    controls = '0; // Unimplemented class
    case (instr.dp.op)
      opDp: begin
        if (instr.dp.i)
          controls = 10'b00_00_1_0_1_0_0_1;   // Immediate operand
        else
          controls = 10'b00_00_0_0_1_0_0_1;   // Register operand or multiply
      end
      opMem: begin
        if (instr.mem.flags[0])
          controls = 10'b00_01_1_1_1_0_0_0;   // LDR
        else
          controls = 10'b10_01_1_0_0_1_0_0;   // STR
      end
      opBranch: controls = 10'b01_10_1_0_0_0_1_0;
      default: controls = '0;
    endcase
  end

  assign {regSrc, immSrc, aluSrc, memtoReg, regWrite, memWrite, branch, aluOp} = controls;

  always_comb begin
    if (aluOp) begin
      dec.aluControl = instr.dp.cmd;
      dec.flagWrite  = {2{instr.dp.s}};   // S sets both halves
    end else begin
      dec.aluControl = aluAdd;
      dec.flagWrite  = 2'b00;
    end
  end

  assign dec.multControl = isMult ? instr.dp.cmd[multCtrlW-1:0] : '0;

  assign dec.aluSrc   = aluSrc;
  assign dec.memtoReg = memtoReg;
  assign dec.regWrite = regWrite;
  assign dec.memWrite = memWrite;
  assign dec.branch   = branch;
  assign dec.pcSrc    = (regWrite && (instr.dp.rd == pcReg)) || branch;  // Any write to R15
  assign dec.cond     = instr.dp.cond;

endmodule

// ==== design/condUnit.sv ====
`timescale 1ns/10ps

module condUnit (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         enable,
  input  logic [armCtrlPkg::condW-1:0] cond,
  input  logic [1:0]                   flagWrite,
  input  logic [armCtrlPkg::flagW-1:0] aluFlags,
  output logic                         condEx,
  output logic [armCtrlPkg::flagW-1:0] flags
);
  import armCtrlPkg::*;

  logic n, z, c, v;

  assign {n, z, c, v} = flags;

  always_comb begin
    case (cond)
      condEq: condEx = z;
      condNe: condEx = !z;
      condCs: condEx = c;
      condCc: condEx = !c;
      condMi: condEx = n;
      condPl: condEx = !n;
      condVs: condEx = v;
      condVc: condEx = !v;
      condHi: condEx = !z && c;
      condLs: condEx = z || !c;
      condGe: condEx = (n == v);
      condLt: condEx = (n != v);
      condGt: condEx = !z && (n == v);
      condLe: condEx = z || (n != v);
      condAl: condEx = 1'b1;
      default: condEx = 1'b0;   // 1111 never executes here
    endcase
  end

  // Flags change only for an instruction that passed its own condition
  always_ff @(posedge clk) begin
    if (reset) begin
      flags <= '0;
    end else if (enable && condEx) begin
      if (flagWrite[1]) flags[3:2] <= aluFlags[3:2];  // N Z
      if (flagWrite[0]) flags[1:0] <= aluFlags[1:0];  // C V
    end
  end

  flagsKnown: assert property (@(posedge clk) disable iff (reset) !$isunknown(flags));

endmodule

// ==== design/controller.sv ====
`timescale 1ns/10ps

module controller (
  input  logic                             clk,
  input  logic                             reset,
  input  armCtrlPkg::armInstrT             instrD,
  input  logic [armCtrlPkg::flagW-1:0]     flagsE,
  output logic [1:0]                       regSrcD,
  output logic [1:0]                       immSrcD,
  output logic                             aluSrcE,
  output logic [armCtrlPkg::aluCtrlW-1:0]  aluControlE,
  output logic [armCtrlPkg::multCtrlW-1:0] multControlE,
  output logic                             carryInE,
  output logic                             branchTakenE,
  output logic                             memWriteM,
  output logic                             regWriteW,
  output logic                             memtoRegW,
  output logic                             pcSrcW,
  hazardIf.ctrl                            haz
);
  import armCtrlPkg::*;

  logic [condW-1:0] condE;
  logic [1:0]       flagWriteE;
  logic             branchE, memWriteE, regWriteE, memtoRegE, pcSrcE;
  logic             condExE;
  logic [flagW-1:0] storedFlags;
  logic             memtoRegM, pcSrcM;

  decodeIf decBus ();

  instrDecoder instrDecoder_inst (
    .instr  (instrD),
    .regSrc (regSrcD),
    .immSrc (immSrcD),
    .dec    (decBus)
  );

  // Execute stage where a flush kills only what could change state
  always_ff @(posedge clk) begin
    if (reset) begin
      aluSrcE      <= 1'b0;
      aluControlE  <= '0;
      multControlE <= '0;
      condE        <= '0;
      flagWriteE   <= 2'b00;
      {branchE, memWriteE, regWriteE, memtoRegE, pcSrcE} <= '0;
    end else if (!haz.stallBack) begin
      aluSrcE      <= decBus.aluSrc;
      aluControlE  <= decBus.aluControl;
      multControlE <= decBus.multControl;
      condE        <= decBus.cond;
      if (haz.flushE) begin
        flagWriteE <= 2'b00;   // Bubble
        {branchE, memWriteE, regWriteE, memtoRegE, pcSrcE} <= '0;
      end else begin
        flagWriteE <= decBus.flagWrite;
        {branchE, memWriteE, regWriteE, memtoRegE, pcSrcE} <=
          {decBus.branch, decBus.memWrite, decBus.regWrite, decBus.memtoReg, decBus.pcSrc};
      end
    end
  end

  condUnit condUnit_inst (
    .clk       (clk),
    .reset     (reset),
    .enable    (!haz.stallBack),
    .cond      (condE),
    .flagWrite (flagWriteE),
    .aluFlags  (flagsE),
    .condEx    (condExE),
    .flags     (storedFlags)
  );

  assign branchTakenE = branchE && condExE;
  assign carryInE     = storedFlags[1];   // Stored C

  // Memory stage takes the condition-gated bits
  always_ff @(posedge clk) begin
    if (reset) begin
      {memWriteM, memtoRegM, haz.regWriteM, pcSrcM} <= '0;
    end else if (!haz.stallBack) begin
      memWriteM     <= memWriteE && condExE;
      memtoRegM     <= memtoRegE && condExE;
      haz.regWriteM <= regWriteE && condExE;
      pcSrcM        <= pcSrcE && condExE;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      {regWriteW, memtoRegW, pcSrcW} <= '0;
    end else if (!haz.stallBack) begin
      {regWriteW, memtoRegW, pcSrcW} <= {haz.regWriteM, memtoRegM, pcSrcM};
    end
  end

  assign haz.memtoRegE    = memtoRegE;
  assign haz.branchTakenE = branchTakenE;
  assign haz.pcSrcW       = pcSrcW;
  assign haz.pcWrPendingF = decBus.pcSrc || pcSrcE || pcSrcM;  // PC write still in flight

  // A store never reaches Writeback with a register write
  noStoreWrite: assert property (@(posedge clk) disable iff (reset)
    memWriteM && !haz.stallBack |=> !regWriteW);

  noFlushInStall: assert property (@(posedge clk) disable iff (reset)
    !(haz.flushE && haz.stallBack));

endmodule

// ==== design/hazardUnit.sv ====
`timescale 1ns/10ps

module hazardUnit (
  input  logic  ldUseMatch,
  input  logic  memStall,
  output logic  stallF,
  output logic  stallD,
  output logic  flushD,
  hazardIf.haz  haz
);

  logic ldStall;

  // Load in Execute feeding the instruction in Decode
  assign ldStall = ldUseMatch && haz.memtoRegE;

  assign stallD = ldStall || memStall;
  assign stallF = stallD || haz.pcWrPendingF;

  // Drop wrong-path fetches while the PC is being redirected
  assign flushD = haz.pcWrPendingF || haz.pcSrcW || haz.branchTakenE;

  assign haz.flushE    = (ldStall || haz.branchTakenE) && !memStall;
  assign haz.stallBack = memStall;

endmodule

// ==== design/ctrlSubsystem.sv ====
`timescale 1ns/10ps

module ctrlSubsystem (
  input  logic                             clk,
  input  logic                             reset,
  input  armCtrlPkg::armInstrT             instrD,
  input  logic [armCtrlPkg::flagW-1:0]     flagsE,     // ALU NZCV
  input  logic                             ldUseMatch,
  input  logic                             memStall,
  output logic [1:0]                       regSrcD,
  output logic [1:0]                       immSrcD,
  output logic                             aluSrcE,
  output logic [armCtrlPkg::aluCtrlW-1:0]  aluControlE,
  output logic [armCtrlPkg::multCtrlW-1:0] multControlE,
  output logic                             carryInE,
  output logic                             branchTakenE,
  output logic                             memWriteM,
  output logic                             regWriteW,
  output logic                             memtoRegW,
  output logic                             pcSrcW,
  output logic                             stallF,
  output logic                             stallD,
  output logic                             flushD
);

  hazardIf hazBus ();

  controller controller_inst (
    .clk          (clk),
    .reset        (reset),
    .instrD       (instrD),
    .flagsE       (flagsE),
    .regSrcD      (regSrcD),
    .immSrcD      (immSrcD),
    .aluSrcE      (aluSrcE),
    .aluControlE  (aluControlE),
    .multControlE (multControlE),
    .carryInE     (carryInE),
    .branchTakenE (branchTakenE),
    .memWriteM    (memWriteM),
    .regWriteW    (regWriteW),
    .memtoRegW    (memtoRegW),
    .pcSrcW       (pcSrcW),
    .haz          (hazBus)
  );

  hazardUnit hazardUnit_inst (
    .ldUseMatch (ldUseMatch),
    .memStall   (memStall),
    .stallF     (stallF),
    .stallD     (stallD),
    .flushD     (flushD),
    .haz        (hazBus)
  );

endmodule

// ==== tb/ctrlVectors.svh ====
`ifndef ctrlVectorsSvh
`define ctrlVectorsSvh

  task automatic loadVectors;
    // name, instr, flagsE, ldUseMatch, memStall of that cycle
    // {regSrc, immSrc} now, {aluSrc, aluControl, multControl} and {carryIn, branchTaken} at +1
    // memWriteM at +2, {regWrite, memtoReg, pcSrc} at +3, {stallF, stallD, flushD} now
    addRow("addImm", 32'hE2812005, 4'h0, 1'b0, 1'b0, 4'h0, 8'hA0, 2'b00, 1'b0, 3'b100, 3'b000);
    addRow("mla", 32'hE0267098, 4'h0, 1'b0, 1'b0, 4'h0, 8'h09, 2'b00, 1'b0, 3'b100, 3'b000);
    addRow("ldrAl", 32'hE5912004, 4'h0, 1'b0, 1'b0, 4'h1, 8'hA0, 2'b00, 1'b0, 3'b110, 3'b000);
    addRow("strAl", 32'hE5812004, 4'h0, 1'b0, 1'b0, 4'h9, 8'hA0, 2'b00, 1'b1, 3'b000, 3'b000);
    // Z clear so EQ fails
    addRow("ldrEq", 32'h05912004, 4'h0, 1'b0, 1'b0, 4'h1, 8'hA0, 2'b00, 1'b0, 3'b000, 3'b000);
    addRow("strEq", 32'h05812004, 4'h0, 1'b0, 1'b0, 4'h9, 8'hA0, 2'b00, 1'b0, 3'b000, 3'b000);
    addRow("subsReg", 32'hE0534005, 4'h0, 1'b0, 1'b0, 4'h0, 8'h10, 2'b00, 1'b0, 3'b100, 3'b000);
    // ALU result of subs is Z and C set
    addRow("beq", 32'h0A000010, 4'h6, 1'b0, 1'b0, 4'h6, 8'hA0, 2'b11, 1'b0, 3'b001, 3'b101);
    addRow("nop8", 32'hEC000000, 4'h0, 1'b0, 1'b0, 4'h0, 8'h20, 2'b10, 1'b0, 3'b000, 3'b101);
    addRow("bne", 32'h1A000010, 4'h0, 1'b0, 1'b0, 4'h6, 8'hA0, 2'b10, 1'b0, 3'b000, 3'b101);
    addRow("nop10", 32'hEC000000, 4'h0, 1'b0, 1'b0, 4'h0, 8'h20, 2'b10, 1'b0, 3'b000, 3'b101);
    addRow("bcs", 32'h2A000010, 4'h0, 1'b0, 1'b0, 4'h6, 8'hA0, 2'b11, 1'b0, 3'b001, 3'b101);
    addRow("nop12", 32'hEC000000, 4'h0, 1'b0, 1'b0, 4'h0, 8'h20, 2'b10, 1'b0, 3'b000, 3'b101);
    addRow("blt", 32'hBA000010, 4'h0, 1'b0, 1'b0, 4'h6, 8'hA0, 2'b10, 1'b0, 3'b000, 3'b101);
    addRow("nop14", 32'hEC000000, 4'h0, 1'b0, 1'b0, 4'h0, 8'h20, 2'b10, 1'b0, 3'b000, 3'b101);
    addRow("ldrUse", 32'hE5912004, 4'h0, 1'b0, 1'b0, 4'h1, 8'hA0, 2'b10, 1'b0, 3'b110, 3'b000);
    addRow("addStall", 32'hE0823001, 4'h0, 1'b1, 1'b0, 4'h0, 8'h20, 2'b10, 1'b0, 3'b000, 3'b110);
    addRow("addRetry", 32'hE0823001, 4'h0, 1'b0, 1'b0, 4'h0, 8'h20, 2'b10, 1'b0, 3'b100, 3'b000);
    addRow("addPc", 32'hE281F005, 4'h0, 1'b0, 1'b0, 4'h0, 8'hA0, 2'b10, 1'b0, 3'b101, 3'b101);
    addRow("nop19", 32'hEC000000, 4'h0, 1'b0, 1'b0, 4'h0, 8'h20, 2'b10, 1'b0, 3'b000, 3'b101);
    addRow("nop20", 32'hEC000000, 4'h0, 1'b0, 1'b0, 4'h0, 8'h20, 2'b10, 1'b0, 3'b000, 3'b101);
    addRow("nop21", 32'hEC000000, 4'h0, 1'b0, 1'b0, 4'h0, 8'h20, 2'b10, 1'b0, 3'b000, 3'b001);
    addRow("ldrHold", 32'hE5912004, 4'h0, 1'b0, 1'b0, 4'h1, 8'hA0, 2'b10, 1'b0, 3'b110, 3'b000);
    addRow("nop23", 32'hEC000000, 4'h0, 1'b0, 1'b0, 4'h0, 8'h20, 2'b10, 1'b0, 3'b000, 3'b000);
    addRow("nop24", 32'hEC000000, 4'h0, 1'b0, 1'b0, 4'h0, 8'h20, 2'b10, 1'b0, 3'b000, 3'b000);
    addRow("memStall1", 32'hEC000000, 4'h0, 1'b0, 1'b1, 4'h0, 8'h20, 2'b10, 1'b0, 3'b000, 3'b110);
    addRow("memStall2", 32'hEC000000, 4'h0, 1'b0, 1'b1, 4'h0, 8'h20, 2'b10, 1'b0, 3'b000, 3'b110);
  endtask

`endif

// ==== tb/ctrlTb.sv ====
`timescale 1ns/10ps

module ctrlTb;
  import armCtrlPkg::*;

  localparam int maxRows  = 32;
  localparam int resetMax = 10;   // Cycles allowed for reset release
  localparam logic [31:0] nopWord = 32'hEC000000;   // Unimplemented class, no control

  logic                 clk;
  logic                 reset;
  armInstrT             instrD;
  logic [flagW-1:0]     flagsE;
  logic                 ldUseMatch;
  logic                 memStall;
  logic [1:0]           regSrcD;
  logic [1:0]           immSrcD;
  logic                 aluSrcE;
  logic [aluCtrlW-1:0]  aluControlE;
  logic [multCtrlW-1:0] multControlE;
  logic                 carryInE;
  logic                 branchTakenE;
  logic                 memWriteM;
  logic                 regWriteW;
  logic                 memtoRegW;
  logic                 pcSrcW;
  logic                 stallF;
  logic                 stallD;
  logic                 flushD;

  string            rowName [maxRows];
  armInstrT         rowInstr [maxRows];
  logic [flagW-1:0] rowFlags [maxRows];
  logic             rowLdUse [maxRows];
  logic             rowStall [maxRows];
  logic [3:0]       expDec [maxRows];
  logic [7:0]       expEx [maxRows];
  logic [1:0]       expCb [maxRows];
  logic             expMw [maxRows];
  logic [2:0]       expWb [maxRows];
  logic [2:0]       expHz [maxRows];
  logic             rowBad [maxRows];

  int         numRows;
  int         errorCount;
  int         passCount;
  logic [2:0] wbExpected;
  logic [2:0] wbLast;

  ctrlSubsystem ctrlSubsystem_inst (
    .clk          (clk),
    .reset        (reset),
    .instrD       (instrD),
    .flagsE       (flagsE),
    .ldUseMatch   (ldUseMatch),
    .memStall     (memStall),
    .regSrcD      (regSrcD),
    .immSrcD      (immSrcD),
    .aluSrcE      (aluSrcE),
    .aluControlE  (aluControlE),
    .multControlE (multControlE),
    .carryInE     (carryInE),
    .branchTakenE (branchTakenE),
    .memWriteM    (memWriteM),
    .regWriteW    (regWriteW),
    .memtoRegW    (memtoRegW),
    .pcSrcW       (pcSrcW),
    .stallF       (stallF),
    .stallD       (stallD),
    .flushD       (flushD)
  );

  always #50 clk = ~clk;

  task automatic addRow(input string name, input armInstrT instr, input logic [3:0] flags,
                        input logic ldUse, input logic stall, input logic [3:0] dec,
                        input logic [7:0] ex, input logic [1:0] cb, input logic mw,
                        input logic [2:0] wb, input logic [2:0] hz);
    rowName[numRows]  = name;
    rowInstr[numRows] = instr;
    rowFlags[numRows] = flags;
    rowLdUse[numRows] = ldUse;
    rowStall[numRows] = stall;
    expDec[numRows]   = dec;
    expEx[numRows]    = ex;
    expCb[numRows]    = cb;
    expMw[numRows]    = mw;
    expWb[numRows]    = wb;
    expHz[numRows]    = hz;
    rowBad[numRows]   = 1'b0;
    numRows++;
  endtask

  `include "ctrlVectors.svh"

  task automatic reportMismatch(input int row, input string field, input logic [31:0] expVal,
                                input logic [31:0] actVal);
    $display("error %s %s expected %0h actual %0h", rowName[row], field, expVal, actVal);
    errorCount++;
    rowBad[row] = 1'b1;
  endtask

  // Cycle cyc sees Decode of row cyc, Execute of cyc-1, Memory of cyc-2, Writeback of cyc-3
  task automatic checkCycle(input int cyc);
    int r;
    if (cyc < numRows) begin
      if ({regSrcD, immSrcD} !== expDec[cyc])
        reportMismatch(cyc, "decode", expDec[cyc], {regSrcD, immSrcD});
      if ({stallF, stallD, flushD} !== expHz[cyc])
        reportMismatch(cyc, "hazard", expHz[cyc], {stallF, stallD, flushD});
    end
    r = cyc - 1;
    if (r >= 0 && r < numRows) begin
      if ({aluSrcE, aluControlE, multControlE} !== expEx[r])
        reportMismatch(r, "execute", expEx[r], {aluSrcE, aluControlE, multControlE});
      if ({carryInE, branchTakenE} !== expCb[r])
        reportMismatch(r, "carry/branch", expCb[r], {carryInE, branchTakenE});
    end
    r = cyc - 2;
    if (r >= 0 && r < numRows) begin
      if (memWriteM !== expMw[r])
        reportMismatch(r, "memWriteM", expMw[r], memWriteM);
    end
    r = cyc - 3;
    // Memory stall last cycle, so Writeback still shows what it showed then
    if (cyc >= 1 && cyc - 1 < numRows && rowStall[cyc-1])
      wbExpected = wbLast;
    else if (r >= 0)
      wbExpected = expWb[r];
    else
      wbExpected = 3'b000;
    wbLast = wbExpected;
    if (r >= 0 && r < numRows) begin
      if ({regWriteW, memtoRegW, pcSrcW} !== wbExpected)
        reportMismatch(r, "writeback", wbExpected, {regWriteW, memtoRegW, pcSrcW});
      if (rowBad[r]) begin
        $display("%-10s FAIL", rowName[r]);
      end else begin
        $display("%-10s ok", rowName[r]);
        passCount++;
      end
    end
  endtask

  initial begin
    int cyc;
    int waitCount;
    clk        = 1'b0;
    reset      = 1'b1;
    instrD     = nopWord;
    flagsE     = '0;
    ldUseMatch = 1'b0;
    memStall   = 1'b0;
    numRows    = 0;
    errorCount = 0;
    passCount  = 0;
    wbLast     = 3'b000;
    loadVectors();

    repeat (2) @(posedge clk);
    reset <= 1'b0;
    waitCount = 0;
    while (reset !== 1'b0 && waitCount < resetMax) begin
      @(posedge clk);
      waitCount++;
    end

    if (reset !== 1'b0) begin
      $display("Reset was never released, table not run");
      $display("Errors found");
    end else begin
      for (cyc = 0; cyc < numRows + 3; cyc++) begin
        if (cyc < numRows) begin
          instrD     <= rowInstr[cyc];
          flagsE     <= rowFlags[cyc];
          ldUseMatch <= rowLdUse[cyc];
          memStall   <= rowStall[cyc];
        end else begin
          instrD     <= nopWord;   // Drain the pipe
          flagsE     <= '0;
          ldUseMatch <= 1'b0;
          memStall   <= 1'b0;
        end
        @(negedge clk);
        checkCycle(cyc);
        @(posedge clk);
      end
      $display("%0d rows, %0d passed, %0d errors", numRows, passCount, errorCount);
      if (errorCount == 0)
        $display("No errors");
      else
        $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+tb
design/armCtrlPkg.sv
design/decodeIf.sv
design/hazardIf.sv
design/instrDecoder.sv
design/condUnit.sv
design/controller.sv
design/hazardUnit.sv
design/ctrlSubsystem.sv
tb/ctrlTb.sv
